//--- Bender.yml
package:
  name: fetch_front

sources:
  - logic/fetch_pkg.sv
  - logic/line_fill.sv
  - logic/line_buffer.sv
  - logic/inst_queue.sv
  - logic/fetch_ctrl.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - bench/burst_mem_model.sv
      - bench/tb_fetch_top.sv

//--- bench/burst_mem_model.sv
`timescale 1ns/1ps

module burst_mem_model (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [fetch_pkg::XLEN-1:0]      mem_addr_i,
    input  logic                            mem_read_i,
    output logic                            mem_ready_o,
    output logic [fetch_pkg::BEAT_W-1:0]    mem_rdata_o,
    output logic                            mem_rvalid_o,
    output int                              reads_o,
    output int                              bursts_o,
    output int                              abandoned_o,
    output logic [fetch_pkg::XLEN-1:0]      last_addr_o
);
    localparam logic [31:0] DATA_KEY = 32'h5a5a0000;

    typedef enum logic [1:0] {
        M_IDLE,
        M_WAIT,
        M_GAP,
        M_BEATS
    } model_state_e;

    model_state_e    state;
    integer          seed = 86;
    int              wait_cycles;
    int              count;
    int              beat;

    // each word holds its own byte address xor the key
    function automatic logic [63:0] beat_data(input logic [31:0] line_addr, input int idx);
        logic [31:0] lo_addr;
        lo_addr = line_addr + 32'(idx * 8);
        return {(lo_addr + 32'd4) ^ DATA_KEY, lo_addr ^ DATA_KEY};
    endfunction

    initial begin
        mem_ready_o  = 1'b0;
        mem_rvalid_o = 1'b0;
        mem_rdata_o  = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            state        <= M_IDLE;
            mem_ready_o  <= 1'b0;
            mem_rvalid_o <= 1'b0;
            reads_o      <= 0;
            bursts_o     <= 0;
            abandoned_o  <= 0;
            last_addr_o  <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (mem_read_i) begin
                        wait_cycles = $unsigned($random(seed)) % 4;
                        reads_o     <= reads_o + 1;
                        last_addr_o <= mem_addr_i;
                        mem_ready_o <= (wait_cycles == 0);
                        count       <= (wait_cycles == 0) ? 2 : wait_cycles;
                        state       <= (wait_cycles == 0) ? M_GAP : M_WAIT;
                    end
                end
                M_WAIT: begin
                    if (!mem_read_i) begin
                        abandoned_o <= abandoned_o + 1;
                        state       <= M_IDLE;
                    end else if (count == 1) begin
                        mem_ready_o <= 1'b1;
                        count       <= 2;
                        state       <= M_GAP;
                    end else begin
                        count <= count - 1;
                    end
                end
                // two idle cycles after the accepting edge
                M_GAP: begin
                    mem_ready_o <= 1'b0;
                    if (count == 0) begin
                        mem_rvalid_o <= 1'b1;
                        mem_rdata_o  <= beat_data(last_addr_o, 0);
                        beat         <= 1;
                        state        <= M_BEATS;
                    end else begin
                        count <= count - 1;
                    end
                end
                M_BEATS: begin
                    if (beat == fetch_pkg::BEATS_PER_LINE) begin
                        mem_rvalid_o <= 1'b0;
                        bursts_o     <= bursts_o + 1;
                        state        <= M_IDLE;
                    end else begin
                        mem_rdata_o <= beat_data(last_addr_o, beat);
                        beat        <= beat + 1;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

endmodule

//--- bench/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;
    localparam logic [31:0] RESET_PC    = 32'haaaaa000;
    localparam int          QUEUE_DEPTH = 8;
    localparam logic [31:0] DATA_KEY    = 32'h5a5a0000;
    localparam int          TIMEOUT     = 200;
    localparam logic [31:0] LINE_B      = 32'h40000400;

    logic                       clk;
    logic                       rst;
    fetch_pkg::redirect_t       redirect;
    logic                       deq;
    fetch_pkg::fetch_entry_t    entry;
    logic                       empty;
    logic [31:0]                mem_addr;
    logic [63:0]                mem_rdata;
    logic                       mem_read;
    logic                       mem_ready;
    logic                       mem_rvalid;
    int                         reads;
    int                         bursts;
    int                         abandoned;
    logic [31:0]                last_addr;
    int                         errors;
    int                         tests_run;
    int                         tests_failed;
    logic [31:0]                next_pc;
    logic [31:0]                next_order;

    fetch_top #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(QUEUE_DEPTH)) dut (
        .clk(clk), .rst(rst), .redirect_i(redirect), .deq_i(deq), .entry_o(entry),
        .empty_o(empty), .mem_addr_o(mem_addr), .mem_read_o(mem_read),
        .mem_ready_i(mem_ready), .mem_rdata_i(mem_rdata), .mem_rvalid_i(mem_rvalid)
    );

    burst_mem_model u_mem (
        .clk(clk), .rst(rst), .mem_addr_i(mem_addr), .mem_read_i(mem_read),
        .mem_ready_o(mem_ready), .mem_rdata_o(mem_rdata), .mem_rvalid_o(mem_rvalid),
        .reads_o(reads), .bursts_o(bursts), .abandoned_o(abandoned), .last_addr_o(last_addr)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] expected_inst(input logic [31:0] pc);
        return pc ^ DATA_KEY;
    endfunction

    task automatic mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic timed_out(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err0);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic send_redirect(input logic [31:0] target);
        @(posedge clk);
        redirect <= '{valid: 1'b1, pc: target};
        @(posedge clk);
        redirect <= '0;
    endtask

    // head entry is captured at the falling edge, then popped
    task automatic pop_entry(output fetch_pkg::fetch_entry_t e, output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        e = '0;
        @(negedge clk);
        while (empty && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (empty) begin
            timed_out("a queue entry");
        end else begin
            e = entry;
            ok = 1'b1;
            @(posedge clk);
            deq <= 1'b1;
            @(posedge clk);
            deq <= 1'b0;
        end
    endtask

    task automatic pop_sequence(input int count);
        fetch_pkg::fetch_entry_t e;
        bit ok;
        for (int i = 0; i < count; i++) begin
            pop_entry(e, ok);
            if (!ok) begin
                break;
            end
            if (e.pc !== next_pc) begin
                mismatch($sformatf("pc %h, expected %h", e.pc, next_pc));
            end
            if (e.order !== next_order) begin
                mismatch($sformatf("order %0d, expected %0d", e.order, next_order));
            end
            if (e.inst !== expected_inst(next_pc)) begin
                mismatch($sformatf("inst %h at pc %h", e.inst, next_pc));
            end
            next_pc = next_pc + 32'd4;
            next_order = next_order + 32'd1;
        end
    endtask

    // order after a redirect only has to grow
    task automatic pop_after_redirect(input logic [31:0] target, output bit ok);
        fetch_pkg::fetch_entry_t e;
        pop_entry(e, ok);
        if (ok) begin
            if (e.pc !== target) begin
                mismatch($sformatf("pc %h after redirect, expected %h", e.pc, target));
            end
            if (e.inst !== expected_inst(target)) begin
                mismatch($sformatf("inst %h at redirect target %h", e.inst, target));
            end
            if (e.order < next_order) begin
                mismatch($sformatf("order %0d not above earlier %0d", e.order, next_order));
            end
            next_pc = target + 32'd4;
            next_order = e.order + 32'd1;
        end
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        @(negedge clk);
        if (!empty) begin
            mismatch("empty_o low after reset");
        end
        if (mem_read) begin
            mismatch("mem_read_o high after reset");
        end
        pop_sequence(1);
        finish_test("reset", err0);
    endtask

    task automatic test_sequential();
        int err0;
        err0 = errors;
        pop_sequence(20);
        finish_test("sequential fetch", err0);
    endtask

    task automatic test_back_pressure();
        int err0;
        int waited;
        err0 = errors;
        waited = 0;
        @(negedge clk);
        while (empty && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (empty) begin
            timed_out("the queue to hold an entry");
        end else begin
            repeat (30) @(posedge clk);
            pop_sequence(QUEUE_DEPTH + 4);
        end
        finish_test("back-pressure", err0);
    endtask

    task automatic test_redirect();
        int err0;
        bit ok;
        err0 = errors;
        send_redirect(32'h10000104);
        pop_after_redirect(32'h10000104, ok);
        finish_test("redirect", err0);
    endtask

    task automatic test_redirect_in_fill();
        int err0;
        int waited;
        int bursts0;
        bit ok;
        err0 = errors;
        waited = 0;
        send_redirect(32'h20000200);
        @(negedge clk);
        while (!(mem_read && mem_addr == 32'h20000200) && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!(mem_read && mem_addr == 32'h20000200)) begin
            timed_out("the read of line 20000200");
        end else begin
            bursts0 = bursts;
            send_redirect(32'h30000310);
            pop_after_redirect(32'h30000310, ok);
            @(negedge clk);
            if (ok && bursts < bursts0 + 2) begin
                mismatch($sformatf("%0d bursts completed, expected 2", bursts - bursts0));
            end
            if (abandoned != 0) begin
                mismatch($sformatf("%0d reads dropped before ready", abandoned));
            end
        end
        finish_test("redirect during a fill", err0);
    endtask

    task automatic test_line_reuse();
        int err0;
        int waited;
        int reads0;
        bit ok;
        err0 = errors;
        waited = 0;
        send_redirect(LINE_B);
        // queue fills from LINE_B, then the next line is fetched
        @(negedge clk);
        while (!(bursts == reads && last_addr == LINE_B + 32) && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!(bursts == reads && last_addr == LINE_B + 32)) begin
            timed_out("the fill of the line after 40000400");
        end else begin
            send_redirect(LINE_B + 40);
            @(negedge clk);
            reads0 = reads;
            pop_after_redirect(LINE_B + 40, ok);
            if (ok) begin
                pop_sequence(5);
            end
            waited = 0;
            while (reads == reads0 && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (reads == reads0) begin
                timed_out("the read of the next line");
            end else if (reads != reads0 + 1 || last_addr !== LINE_B + 64) begin
                mismatch($sformatf("%0d reads after reuse, last at %h, expected one at %h",
                                   reads - reads0, last_addr, LINE_B + 64));
            end
        end
        finish_test("same-line reuse", err0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        redirect = '0;
        deq = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        next_pc = RESET_PC;
        next_order = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_sequential();
        test_back_pressure();
        test_redirect();
        test_redirect_in_fill();
        test_line_reuse();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- logic/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = 32'haaaaa000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  fetch_pkg::redirect_t          redirect_i,
    input  logic                          hit_i,
    input  logic [fetch_pkg::XLEN-1:0]    inst_i,
    input  logic                          busy_i,
    input  logic                          full_i,
    output logic [fetch_pkg::XLEN-1:0]    pc_o,
    output fetch_pkg::fill_req_t          fill_req_o,
    output logic                          enq_o,
    output fetch_pkg::fetch_entry_t       enq_entry_o,
    output logic                          flush_o
);
    fetch_pkg::fetch_state_e            state_q;
    logic [fetch_pkg::XLEN-1:0]         pc_q;
    logic [fetch_pkg::ORDER_W-1:0]      order_q;
    logic                               req_valid_q;
    logic [fetch_pkg::XLEN-1:0]         line_addr;

    assign line_addr = {pc_q[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_W],
                        {fetch_pkg::OFFSET_W{1'b0}}};

    assign pc_o        = pc_q;
    assign flush_o     = redirect_i.valid;
    assign fill_req_o  = '{valid: req_valid_q, line_addr: line_addr};
    assign enq_entry_o = '{order: order_q, pc: pc_q, inst: inst_i};

    // a redirect cycle never enqueues
    assign enq_o = (state_q == fetch_pkg::FETCH_RUN) && hit_i && !full_i
                   && !redirect_i.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= fetch_pkg::FETCH_RUN;
            pc_q        <= RESET_PC;
            order_q     <= '0;
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= 1'b0;
            if (enq_o) begin
                order_q <= order_q + 1'b1;
            end
            if (redirect_i.valid) begin
                pc_q <= redirect_i.pc;
            end else begin
                case (state_q)
                    fetch_pkg::FETCH_RUN: begin
                        if (enq_o) begin
                            pc_q <= pc_q + 32'd4;
                        end else if (!hit_i && !busy_i) begin
                            req_valid_q <= 1'b1;
                            state_q     <= fetch_pkg::FETCH_MISS;
                        end
                    end
                    fetch_pkg::FETCH_MISS: begin
                        // busy is still low in the cycle the request goes out
                        if (!busy_i && !req_valid_q) begin
                            state_q <= fetch_pkg::FETCH_RUN;
                        end
                    end
                    default: state_q <= fetch_pkg::FETCH_RUN;
                endcase
            end
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc_q[1:0] == 2'b00)
        else $error("fetch_ctrl: pc not word aligned");

    no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        fill_req_o.valid |-> !busy_i)
        else $error("fetch_ctrl: fill request while line fill busy");

endmodule

//--- logic/fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN           = 32;
    localparam int LINE_W         = 256;
    localparam int BEAT_W         = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_W       = 5;
    localparam int ORDER_W        = 32;

    // one queue slot, order is the fetch sequence number
    typedef struct packed {
        logic [ORDER_W-1:0] order;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    inst;
    } fetch_entry_t;

    // line_addr has the offset bits cleared
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] line_addr;
    } fill_req_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   line_addr;
        logic [LINE_W-1:0] data;
    } line_fill_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

    typedef enum logic {
        FETCH_RUN,
        FETCH_MISS
    } fetch_state_e;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_ADDR,
        FILL_BEATS
    } fill_state_e;

endpackage

//--- logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC    = 32'haaaaa000,
    parameter int                         QUEUE_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  fetch_pkg::redirect_t          redirect_i,
    input  logic                          deq_i,
    output fetch_pkg::fetch_entry_t       entry_o,
    output logic                          empty_o,
    output logic [fetch_pkg::XLEN-1:0]    mem_addr_o,
    output logic                          mem_read_o,
    input  logic                          mem_ready_i,
    input  logic [fetch_pkg::BEAT_W-1:0]  mem_rdata_i,
    input  logic                          mem_rvalid_i
);
    logic [fetch_pkg::XLEN-1:0]    pc;
    logic                          hit;
    logic [fetch_pkg::XLEN-1:0]    inst;
    logic                          busy;
    logic                          full;
    logic                          enq;
    logic                          flush;
    fetch_pkg::fill_req_t          fill_req;
    fetch_pkg::line_fill_t         line;
    fetch_pkg::fetch_entry_t       enq_entry;

    fetch_ctrl #(.RESET_PC(RESET_PC)) u_ctrl (
        .clk(clk), .rst(rst), .redirect_i(redirect_i),
        .hit_i(hit), .inst_i(inst), .busy_i(busy), .full_i(full),
        .pc_o(pc), .fill_req_o(fill_req), .enq_o(enq),
        .enq_entry_o(enq_entry), .flush_o(flush)
    );

    line_buffer u_line_buffer (
        .clk(clk), .rst(rst), .pc_i(pc), .line_i(line),
        .hit_o(hit), .inst_o(inst)
    );

    line_fill u_line_fill (
        .clk(clk), .rst(rst), .req_i(fill_req), .busy_o(busy), .line_o(line),
        .mem_addr_o(mem_addr_o), .mem_read_o(mem_read_o), .mem_ready_i(mem_ready_i),
        .mem_rdata_i(mem_rdata_i), .mem_rvalid_i(mem_rvalid_i)
    );

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .rst(rst), .flush_i(flush), .enq_i(enq), .data_i(enq_entry),
        .full_o(full), .deq_i(deq_i), .data_o(entry_o), .empty_o(empty_o)
    );

endmodule

//--- logic/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush_i,
    input  logic                      enq_i,
    input  fetch_pkg::fetch_entry_t   data_i,
    output logic                      full_o,
    input  logic                      deq_i,
    output fetch_pkg::fetch_entry_t   data_o,
    output logic                      empty_o
);
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_pkg::fetch_entry_t   mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [CNT_W-1:0]          count_q;
    logic                      do_enq;
    logic                      do_deq;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(QUEUE_DEPTH));
    assign empty_o = (count_q == '0);
    assign do_enq  = enq_i && !full_o;
    assign do_deq  = deq_i && !empty_o;
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_deq) rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q <= count_q + CNT_W'(do_enq) - CNT_W'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // the producer must hold off on its own when the queue fills
    no_enq_when_full: assert property (@(posedge clk) disable iff (rst)
        enq_i |-> !full_o)
        else $error("inst_queue: enqueue while full");

endmodule

//--- logic/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [fetch_pkg::XLEN-1:0]    pc_i,
    input  fetch_pkg::line_fill_t         line_i,
    output logic                          hit_o,
    output logic [fetch_pkg::XLEN-1:0]    inst_o
);
    localparam int TAG_W      = fetch_pkg::XLEN - fetch_pkg::OFFSET_W;
    localparam int WORD_SEL_W = $clog2(fetch_pkg::WORDS_PER_LINE);

    logic                            valid_q;
    logic [TAG_W-1:0]                tag_q;
    logic [fetch_pkg::LINE_W-1:0]    data_q;
    logic [WORD_SEL_W-1:0]           word_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (line_i.valid) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_i.valid) begin
            tag_q  <= line_i.line_addr[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_W];
            data_q <= line_i.data;
        end
    end

    // word index sits just above the byte bits
    assign word_sel = pc_i[2 +: WORD_SEL_W];
    assign hit_o    = valid_q && (pc_i[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_W] == tag_q);
    assign inst_o   = data_q[word_sel*fetch_pkg::XLEN +: fetch_pkg::XLEN];

endmodule

//--- logic/line_fill.sv
`timescale 1ns/1ps

module line_fill (
    input  logic                              clk,
    input  logic                              rst,
    input  fetch_pkg::fill_req_t              req_i,
    output logic                              busy_o,
    output fetch_pkg::line_fill_t             line_o,
    output logic [fetch_pkg::XLEN-1:0]        mem_addr_o,
    output logic                              mem_read_o,
    input  logic                              mem_ready_i,
    input  logic [fetch_pkg::BEAT_W-1:0]      mem_rdata_i,
    input  logic                              mem_rvalid_i
);
    localparam int BEAT_IDX_W = $clog2(fetch_pkg::BEATS_PER_LINE);

    fetch_pkg::fill_state_e          state_q;
    logic [fetch_pkg::XLEN-1:0]      addr_q;
    logic [fetch_pkg::LINE_W-1:0]    data_q;
    logic [BEAT_IDX_W-1:0]           beat_q;
    logic                            done_q;

    assign busy_o     = (state_q != fetch_pkg::FILL_IDLE);
    assign mem_read_o = (state_q == fetch_pkg::FILL_ADDR);
    assign mem_addr_o = addr_q;
    assign line_o     = '{valid: done_q, line_addr: addr_q, data: data_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= fetch_pkg::FILL_IDLE;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                fetch_pkg::FILL_IDLE: begin
                    if (req_i.valid) begin
                        beat_q  <= '0;
                        state_q <= fetch_pkg::FILL_ADDR;
                    end
                end
                fetch_pkg::FILL_ADDR: begin
                    if (mem_ready_i) begin
                        state_q <= fetch_pkg::FILL_BEATS;
                    end
                end
                fetch_pkg::FILL_BEATS: begin
                    if (mem_rvalid_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == BEAT_IDX_W'(fetch_pkg::BEATS_PER_LINE - 1)) begin
                            done_q  <= 1'b1;
                            state_q <= fetch_pkg::FILL_IDLE;
                        end
                    end
                end
                default: state_q <= fetch_pkg::FILL_IDLE;
            endcase
        end
    end

    // beat 0 lands in the low bits
    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::FILL_IDLE && req_i.valid) begin
            addr_q <= req_i.line_addr;
        end
        if (state_q == fetch_pkg::FILL_BEATS && mem_rvalid_i) begin
            data_q[beat_q*fetch_pkg::BEAT_W +: fetch_pkg::BEAT_W] <= mem_rdata_i;
        end
    end

    rvalid_in_beats: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid_i |-> state_q == fetch_pkg::FILL_BEATS)
        else $error("line_fill: rvalid outside of a burst");

endmodule

//--- src.f
logic/fetch_pkg.sv
logic/line_fill.sv
logic/line_buffer.sv
logic/inst_queue.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
bench/burst_mem_model.sv
bench/tb_fetch_top.sv
